//--- hw/muldiv_op_pkg.sv
package muldiv_op_pkg;

    // Word width fixed by RV32
    localparam int xlen = 32;

    typedef enum logic [1:0] {
        mul    = 2'b00,
        mulh   = 2'b01,
        mulhsu = 2'b10,
        mulhu  = 2'b11
    } mul_op_e;

    // Bit 1 picks the remainder, bit 0 picks unsigned
    typedef enum logic [1:0] {
        div  = 2'b00,
        divu = 2'b01,
        rem  = 2'b10,
        remu = 2'b11
    } div_op_e;

    // Same funct bits, decoded by muldiv_sel
    typedef union packed {
        mul_op_e mul_op;
        div_op_e div_op;
    } muldiv_op_u;

endpackage

//--- hw/operand_status_pkg.sv
package operand_status_pkg;

    // Special values seen on the two operands
    typedef struct packed {
        logic b_minus_one;
        logic b_one;
        logic b_zero;
        logic a_minus_one;
        logic a_one;
        logic a_zero;
    } operand_status_t;

    localparam int a_zero_idx      = 0;
    localparam int a_one_idx       = 1;
    localparam int a_minus_one_idx = 2;
    localparam int b_zero_idx      = 3;
    localparam int b_one_idx       = 4;
    localparam int b_minus_one_idx = 5;

endpackage

//--- hw/muldiv_ctrl_if.sv
`timescale 1ns/100ps

interface muldiv_ctrl_if;

    logic div_start;          // Level, held until div_rdy
    logic reg_ab_en;          // Operand capture
    logic reg_muldiv_en;      // Result register load
    logic mux_muldiv_sel;     // 1 selects divider as result source
    logic mux_muldiv_out_sel; // 1 routes division register to result
    logic div_rdy;            // One-cycle pulse from divider

    modport ctrl (
        output div_start,
        output reg_ab_en,
        output reg_muldiv_en,
        output mux_muldiv_sel,
        output mux_muldiv_out_sel,
        input  div_rdy
    );

    modport dp (
        input  div_start,
        input  reg_ab_en,
        input  reg_muldiv_en,
        input  mux_muldiv_sel,
        input  mux_muldiv_out_sel,
        output div_rdy
    );

endinterface

//--- hw/operand_classifier.sv
`timescale 1ns/100ps

module operand_classifier (
    input  logic [muldiv_op_pkg::xlen-1:0]       a,
    input  logic [muldiv_op_pkg::xlen-1:0]       b,
    output operand_status_pkg::operand_status_t  status,
    output logic [muldiv_op_pkg::xlen-1:0]       a_2c,
    output logic [muldiv_op_pkg::xlen-1:0]       b_2c
);

    import muldiv_op_pkg::*;

    always_comb begin
        status.a_zero      = (a == '0);
        status.a_one       = (a == xlen'(1));
        status.a_minus_one = (a == '1);
        status.b_zero      = (b == '0);
        status.b_one       = (b == xlen'(1));
        status.b_minus_one = (b == '1);
    end

    // Negations feed the fast path for -1 operands
    assign a_2c = ~a + 1'b1;
    assign b_2c = ~b + 1'b1;

endmodule

//--- hw/muldiv_ctrl.sv
`timescale 1ns/100ps

module muldiv_ctrl (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    input  logic                                muldiv_sel,
    input  muldiv_op_pkg::muldiv_op_u           op,
    input  operand_status_pkg::operand_status_t status,
    input  logic [muldiv_op_pkg::xlen-1:0]      a,
    input  logic [muldiv_op_pkg::xlen-1:0]      b,
    input  logic [muldiv_op_pkg::xlen-1:0]      a_2c,
    input  logic [muldiv_op_pkg::xlen-1:0]      b_2c,
    output logic [muldiv_op_pkg::xlen-1:0]      fastres,
    output logic                                mux_fastres_sel,
    output logic                                done,
    muldiv_ctrl_if.ctrl                         ctrl
);

    import muldiv_op_pkg::*;
    import operand_status_pkg::*;

    localparam logic [2:0] s_idle    = 3'd0;
    localparam logic [2:0] s_div     = 3'd1;
    localparam logic [2:0] s_div_out = 3'd2;
    localparam logic [2:0] s_mul1    = 3'd3;
    localparam logic [2:0] s_mul2    = 3'd4;
    localparam logic [2:0] s_mul_out = 3'd5;

    logic [2:0]      state;
    logic [2:0]      next_state;
    logic            fast_hit;
    logic            a_unsigned;
    logic            b_unsigned;
    logic            x_from_b;
    logic            x_neg;
    logic            x_signed;
    logic [xlen-1:0] x;
    logic [xlen-1:0] x_2c;

    // Operands read as unsigned, where -1 means 2^32-1
    assign a_unsigned = muldiv_sel ? op.div_op[0] : (op.mul_op == mulhu);
    assign b_unsigned = muldiv_sel ? op.div_op[0] : (op.mul_op inside {mulhsu, mulhu});

    // When one operand is +1 or -1 the product is +x or -x
    assign x_from_b = status.a_one || status.a_minus_one;
    assign x        = x_from_b ? b : a;
    assign x_2c     = x_from_b ? b_2c : a_2c;
    assign x_neg    = x_from_b ? status.a_minus_one : status.b_minus_one;
    assign x_signed = (op.mul_op == mulh) || (!x_from_b && op.mul_op == mulhsu);

    always_comb begin
        fast_hit = 1'b1;
        fastres  = '0;
        if (status.a_zero) begin
            // 0/0 still follows the divide-by-zero rule
            if (muldiv_sel && status.b_zero && !op.div_op[1])
                fastres = '1;
        end else if (status.b_zero) begin
            if (muldiv_sel)
                fastres = op.div_op[1] ? a : '1;
        end else if (status == '0) begin
            fast_hit = 1'b0;
        end else if ((status.a_minus_one && a_unsigned) ||
                     (status.b_minus_one && b_unsigned)) begin
            fast_hit = 1'b0;                          // MULHU/DIVU style, slow path
        end else if (!muldiv_sel) begin
            if (op.mul_op == mul)
                fastres = x_neg ? x_2c : x;
            else if (x_signed)
                fastres = {xlen{x[xlen-1] ^ x_neg}};  // High word is sign of +-x
            else
                fastres = {xlen{x_neg}};
        end else if (status.b_one || status.b_minus_one) begin
            fastres = op.div_op[1] ? '0 : (status.b_one ? a : a_2c);
        end else begin
            // Dividend is +-1 and divisor larger in magnitude
            fastres = op.div_op[1] ? a : '0;
        end
    end

    assign mux_fastres_sel = fast_hit && (state == s_idle);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            state <= s_idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state              = state;
        ctrl.div_start          = 1'b0;
        ctrl.reg_ab_en          = 1'b0;
        ctrl.reg_muldiv_en      = 1'b0;
        ctrl.mux_muldiv_sel     = 1'b0;
        ctrl.mux_muldiv_out_sel = 1'b0;
        done                    = 1'b0;
        case (state)
            s_idle: begin
                if (start && fast_hit) begin
                    done = 1'b1;                      // Answered in the start cycle
                end else if (start) begin
                    ctrl.reg_ab_en = 1'b1;
                    next_state     = muldiv_sel ? s_div : s_mul1;
                end
            end
            s_div: begin
                ctrl.mux_muldiv_sel = 1'b1;
                if (ctrl.div_rdy) begin
                    ctrl.reg_muldiv_en = 1'b1;
                    next_state         = s_div_out;
                end else begin
                    ctrl.div_start = 1'b1;
                end
            end
            s_div_out: begin
                ctrl.mux_muldiv_out_sel = 1'b1;
                done                    = 1'b1;
                next_state              = s_idle;
            end
            s_mul1: next_state = s_mul2;              // Partial products settle
            s_mul2: begin
                ctrl.reg_muldiv_en = 1'b1;
                next_state         = s_mul_out;
            end
            s_mul_out: begin
                ctrl.reg_muldiv_en = 1'b1;
                done               = 1'b1;
                next_state         = s_idle;
            end
            default: next_state = s_idle;
        endcase
    end

    done_not_in_div: assert property (@(posedge clk) disable iff (!reset)
        !(done && ctrl.div_start));

    // A zero dividend is always answered by the fast path
    capture_only_on_start: assert property (@(posedge clk) disable iff (!reset)
        ctrl.reg_ab_en |-> (state == s_idle) && start && !status[a_zero_idx]);

endmodule

//--- hw/restoring_divider.sv
`timescale 1ns/100ps

module restoring_divider (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [muldiv_op_pkg::xlen-1:0]  dividend,
    input  logic [muldiv_op_pkg::xlen-1:0]  divisor,
    input  logic                            is_signed,
    output logic [muldiv_op_pkg::xlen-1:0]  quotient,
    output logic [muldiv_op_pkg::xlen-1:0]  remainder,
    output logic                            rdy
);

    import muldiv_op_pkg::*;

    logic            busy;
    logic [4:0]      count;
    logic [xlen-1:0] quo_q;     // Dividend shifts out, quotient shifts in
    logic [xlen-1:0] rem_q;
    logic [xlen-1:0] dsr_q;
    logic            neg_q;
    logic            neg_r;
    logic            div_zero;
    logic [xlen:0]   rem_shift;
    logic [xlen:0]   rem_next;
    logic            fits;

    assign rem_shift = {rem_q, quo_q[xlen-1]};
    assign fits      = rem_shift >= {1'b0, dsr_q};
    assign rem_next  = fits ? rem_shift - {1'b0, dsr_q} : rem_shift;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy  <= 1'b0;
            count <= '0;
            rdy   <= 1'b0;
        end else begin
            rdy <= 1'b0;
            if (!busy && start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == 5'(xlen - 1)) begin
                    busy <= 1'b0;
                    rdy  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            quo_q    <= (is_signed && dividend[xlen-1]) ? -dividend : dividend;
            dsr_q    <= (is_signed && divisor[xlen-1]) ? -divisor : divisor;
            rem_q    <= '0;
            neg_q    <= is_signed && (dividend[xlen-1] ^ divisor[xlen-1]);
            neg_r    <= is_signed && dividend[xlen-1];
            div_zero <= (divisor == '0);
        end else if (busy) begin
            quo_q <= {quo_q[xlen-2:0], fits};
            rem_q <= rem_next[xlen-1:0];
        end
    end

    // Overflow falls out naturally: |min| / 1 = min, remainder 0
    assign quotient  = div_zero ? '1 : (neg_q ? -quo_q : quo_q);
    assign remainder = neg_r ? -rem_q : rem_q;    // Remainder takes the dividend sign

    rdy_single_cycle: assert property (@(posedge clk) disable iff (!reset)
        rdy |=> !rdy);

endmodule

//--- hw/muldiv_datapath.sv
`timescale 1ns/100ps

module muldiv_datapath (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [muldiv_op_pkg::xlen-1:0]  a,
    input  logic [muldiv_op_pkg::xlen-1:0]  b,
    input  muldiv_op_pkg::muldiv_op_u       op,
    input  logic                            muldiv_sel,
    input  logic [muldiv_op_pkg::xlen-1:0]  fastres,
    input  logic                            mux_fastres_sel,
    muldiv_ctrl_if.dp                       dp,
    output logic [muldiv_op_pkg::xlen-1:0]  result
);

    import muldiv_op_pkg::*;

    localparam int pw = 2 * xlen;

    logic [xlen-1:0]     a_q;
    logic [xlen-1:0]     b_q;
    muldiv_op_u          op_q;
    logic                div_sel_q;
    logic                a_signed;
    logic                b_signed;
    logic signed [xlen:0] a_ext;
    logic signed [xlen:0] b_ext;
    logic signed [16:0]  a_hi;
    logic signed [16:0]  a_lo;
    logic signed [16:0]  b_hi;
    logic signed [16:0]  b_lo;
    logic signed [33:0]  pp_ll;
    logic signed [33:0]  pp_lh;
    logic signed [33:0]  pp_hl;
    logic signed [33:0]  pp_hh;
    logic [pw-1:0]       product_q;
    logic [xlen-1:0]     quotient;
    logic [xlen-1:0]     remainder;
    logic [xlen-1:0]     div_res_q;

    always_ff @(posedge clk) begin
        if (dp.reg_ab_en) begin
            a_q       <= a;
            b_q       <= b;
            op_q      <= op;
            div_sel_q <= muldiv_sel;
        end
    end

    assign a_signed = op_q.mul_op inside {mulh, mulhsu};
    assign b_signed = (op_q.mul_op == mulh);

    // Multiplier inputs stay at zero during a division
    assign a_ext = div_sel_q ? '0 : {a_signed & a_q[xlen-1], a_q};
    assign b_ext = div_sel_q ? '0 : {b_signed & b_q[xlen-1], b_q};

    assign a_hi = a_ext[xlen:xlen/2];
    assign a_lo = {1'b0, a_ext[xlen/2-1:0]};      // Low halves are unsigned
    assign b_hi = b_ext[xlen:xlen/2];
    assign b_lo = {1'b0, b_ext[xlen/2-1:0]};

    // Stage 1, free running
    always_ff @(posedge clk) begin
        pp_ll <= a_lo * b_lo;
        pp_lh <= a_lo * b_hi;
        pp_hl <= a_hi * b_lo;
        pp_hh <= a_hi * b_hi;
    end

    // Stage 2 and the division result register
    always_ff @(posedge clk) begin
        if (dp.reg_muldiv_en && !dp.mux_muldiv_sel)
            product_q <= (pw'(pp_hh) << xlen) + (pw'(pp_lh) << (xlen / 2)) +
                         (pw'(pp_hl) << (xlen / 2)) + pw'(pp_ll);
        if (dp.reg_muldiv_en && dp.mux_muldiv_sel)
            div_res_q <= op_q.div_op[1] ? remainder : quotient;
    end

    restoring_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (dp.div_start),
        .dividend  (a_q),
        .divisor   (b_q),
        .is_signed (!op_q.div_op[0]),
        .quotient  (quotient),
        .remainder (remainder),
        .rdy       (dp.div_rdy)
    );

    always_comb begin
        if (mux_fastres_sel)
            result = fastres;
        else if (dp.mux_muldiv_out_sel)
            result = div_res_q;
        else if (op_q.mul_op == mul)
            result = product_q[xlen-1:0];
        else
            result = product_q[pw-1:xlen];        // MULH* take the upper word
    end

endmodule

//--- hw/muldiv_unit.sv
`timescale 1ns/100ps

module muldiv_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            muldiv_sel,
    input  logic [1:0]                      op,
    input  logic [muldiv_op_pkg::xlen-1:0]  a,
    input  logic [muldiv_op_pkg::xlen-1:0]  b,
    output logic [muldiv_op_pkg::xlen-1:0]  result,
    output logic                            done
);

    import muldiv_op_pkg::*;
    import operand_status_pkg::*;

    operand_status_t status;
    logic [xlen-1:0] a_2c;
    logic [xlen-1:0] b_2c;
    logic [xlen-1:0] fastres;
    logic            mux_fastres_sel;

    muldiv_ctrl_if ctrl_bus ();

    operand_classifier u_classifier (
        .a      (a),
        .b      (b),
        .status (status),
        .a_2c   (a_2c),
        .b_2c   (b_2c)
    );

    muldiv_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .muldiv_sel      (muldiv_sel),
        .op              (op),
        .status          (status),
        .a               (a),
        .b               (b),
        .a_2c            (a_2c),
        .b_2c            (b_2c),
        .fastres         (fastres),
        .mux_fastres_sel (mux_fastres_sel),
        .done            (done),
        .ctrl            (ctrl_bus)
    );

    muldiv_datapath u_datapath (
        .clk             (clk),
        .reset           (reset),
        .a               (a),
        .b               (b),
        .op              (op),
        .muldiv_sel      (muldiv_sel),
        .fastres         (fastres),
        .mux_fastres_sel (mux_fastres_sel),
        .dp              (ctrl_bus),
        .result          (result)
    );

endmodule

//--- testbench/tb_muldiv_unit.sv
`timescale 1ns/100ps

module tb_muldiv_unit;

    logic        clk;
    logic        reset;
    logic        start;
    logic        muldiv_sel;
    logic [1:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic        done;

    logic [31:0] lfsr_state;
    logic [31:0] exp_result;
    string       test_name;
    bit          pending;        // An operation is in flight
    int          checks;
    int          mismatch_count;
    int          fail_count;

    string       mul_names [4] = '{"mul", "mulh", "mulhsu", "mulhu"};
    string       div_names [4] = '{"div", "divu", "rem", "remu"};
    logic [31:0] specials [3]  = '{32'h0, 32'h1, 32'hffff_ffff};

    muldiv_unit DUT (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .muldiv_sel (muldiv_sel),
        .op         (op),
        .a          (a),
        .b          (b),
        .result     (result),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // RISC-V M-extension result, computed on 64-bit values
    function automatic logic [31:0] golden_muldiv(input logic [31:0] a_v, input logic [31:0] b_v,
                                                  input logic sel, input logic [1:0] op_v);
        longint      sa;
        longint      sb;
        longint      ua;
        longint      ub;
        logic [63:0] wide;
        sa = {{32{a_v[31]}}, a_v};
        sb = {{32{b_v[31]}}, b_v};
        ua = {32'h0, a_v};
        ub = {32'h0, b_v};
        if (!sel) begin
            case (op_v)
                2'b00:   wide = sa * sb;
                2'b01:   wide = sa * sb;
                2'b10:   wide = sa * ub;   // Signed times unsigned
                default: wide = ua * ub;
            endcase
            return (op_v == 2'b00) ? wide[31:0] : wide[63:32];
        end
        if (b_v == 32'h0)
            return op_v[1] ? a_v : 32'hffff_ffff;
        if (!op_v[0] && a_v == 32'h8000_0000 && b_v == 32'hffff_ffff)
            return op_v[1] ? 32'h0 : a_v;  // Signed overflow
        if (op_v[0])
            wide = op_v[1] ? ua % ub : ua / ub;
        else
            wide = op_v[1] ? sa % sb : sa / sb;
        return wide[31:0];
    endfunction

    // Zero always answers at once; -1 read as unsigned needs the full unit
    function automatic bit expects_fast(input logic sel, input logic [1:0] op_v,
                                        input logic [31:0] a_v, input logic [31:0] b_v);
        bit a_uns;
        bit b_uns;
        a_uns = sel ? op_v[0] : (op_v == 2'b11);
        b_uns = sel ? op_v[0] : op_v[1];
        if (a_v == 32'h0 || b_v == 32'h0)
            return 1'b1;
        if ((a_v == 32'hffff_ffff && a_uns) || (b_v == 32'hffff_ffff && b_uns))
            return 1'b0;
        return (a_v == 32'h1 || a_v == 32'hffff_ffff || b_v == 32'h1 || b_v == 32'hffff_ffff);
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic run_op(input string label, input logic sel, input logic [1:0] op_v,
                          input logic [31:0] a_v, input logic [31:0] b_v);
        int lat;
        int min_lat;
        int max_lat;
        bit seen;
        if (expects_fast(sel, op_v, a_v, b_v)) begin
            min_lat = 0;
            max_lat = 0;
        end else if (sel) begin
            min_lat = 1;
            max_lat = 100;
        end else begin
            min_lat = 3;
            max_lat = 3;
        end
        @(posedge clk);
        #1;
        muldiv_sel = sel;
        op         = op_v;
        a          = a_v;
        b          = b_v;
        start      = 1'b1;
        exp_result = golden_muldiv(a_v, b_v, sel, op_v);
        test_name  = $sformatf("%s %s a=%h b=%h", label,
                               sel ? div_names[op_v] : mul_names[op_v], a_v, b_v);
        pending    = 1'b1;
        lat        = 0;
        seen       = 1'b0;
        while (!seen && lat < 100) begin
            @(negedge clk);               // Outputs settled mid-cycle
            if (done) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                #1;
                start = 1'b0;
                lat++;
            end
        end
        if (!seen) begin
            $display("Error in %s: done never arrived", test_name);
            fail_count++;
        end else if (lat < min_lat || lat > max_lat) begin
            $display("Error in %s: done came %0d cycles after start, expected %0d to %0d",
                     test_name, lat, min_lat, max_lat);
            fail_count++;
        end
        @(posedge clk);
        #1;
        start   = 1'b0;
        pending = 1'b0;
    endtask

    // Result checker
    always @(negedge clk) begin
        if (reset && done) begin
            checks++;
            if (!pending) begin
                $display("Error: done was raised with no operation in flight");
                fail_count++;
            end else if (result !== exp_result) begin
                $display("Mismatch %s: expected %h, actual %h", test_name, exp_result, result);
                mismatch_count++;
            end
        end
    end

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        int          sel;
        int          k;
        int          i;
        int          s;
        int          t;
        reset          = 1'b0;
        start          = 1'b0;
        muldiv_sel     = 1'b0;
        op             = 2'b00;
        a              = '0;
        b              = '0;
        exp_result     = '0;
        pending        = 1'b0;
        checks         = 0;
        mismatch_count = 0;
        fail_count     = 0;
        lfsr_state     = 32'h394e;
        repeat (16) @(posedge clk);
        #1 reset = 1'b1;

        for (k = 0; k < 4; k++) begin
            for (i = 0; i < 8; i++) begin
                take_random(ra);
                take_random(rb);
                run_op("random", 1'b0, 2'(k), ra, rb);
                ra[31] = i[0];            // Walk through the sign combinations
                rb[31] = i[1];
                run_op("random", 1'b1, 2'(k), ra, rb);
            end
        end

        // Every special value against random values and against each other
        for (sel = 0; sel < 2; sel++) begin
            for (k = 0; k < 4; k++) begin
                for (s = 0; s < 3; s++) begin
                    take_random(ra);
                    run_op("special", sel[0], 2'(k), specials[s], ra);
                    run_op("special", sel[0], 2'(k), ra, specials[s]);
                    for (t = 0; t < 3; t++)
                        run_op("special", sel[0], 2'(k), specials[s], specials[t]);
                end
            end
        end

        for (k = 0; k < 4; k++) begin
            take_random(ra);
            run_op("div by zero", 1'b1, 2'(k), ra, 32'h0);
            run_op("div by zero", 1'b1, 2'(k), 32'h0, 32'h0);
            run_op("overflow", 1'b1, 2'(k), 32'h8000_0000, 32'hffff_ffff);
        end

        // Unsigned -1 takes the slow path
        for (i = 0; i < 4; i++) begin
            take_random(ra);
            run_op("unsigned -1", 1'b0, 2'b11, 32'hffff_ffff, ra);
            run_op("unsigned -1", 1'b0, 2'b11, ra, 32'hffff_ffff);
            run_op("unsigned -1", 1'b1, 2'b01, 32'hffff_ffff, ra);
            run_op("unsigned -1", 1'b1, 2'b01, ra, 32'hffff_ffff);
        end

        repeat (2) @(posedge clk);
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- files.f
hw/muldiv_op_pkg.sv
hw/operand_status_pkg.sv
hw/muldiv_ctrl_if.sv
hw/operand_classifier.sv
hw/muldiv_ctrl.sv
hw/restoring_divider.sv
hw/muldiv_datapath.sv
hw/muldiv_unit.sv
testbench/tb_muldiv_unit.sv

//--- Bender.yml
package:
  name: muldiv_unit

sources:
  - hw/muldiv_op_pkg.sv
  - hw/operand_status_pkg.sv
  - hw/muldiv_ctrl_if.sv
  - hw/operand_classifier.sv
  - hw/muldiv_ctrl.sv
  - hw/restoring_divider.sv
  - hw/muldiv_datapath.sv
  - hw/muldiv_unit.sv
  - target: test
    files:
      - testbench/tb_muldiv_unit.sv
